// ==== common/mem_pkg.sv ====
/* memory port types; word addressed in bytes, reads answer a fixed latency after grant
   and writes get no response */
package mem_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // wen high means read
  typedef struct packed {
    logic  req;
    logic  wen;
    addr_t add;
    be_t   be;
    data_t data;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } mem_rsp_t;

  // cycles from a granted read to r_valid
  localparam int unsigned MEM_RD_LATENCY = 1;

endpackage

// ==== common/cfg_pkg.sv ====
/* APB register map and copy configuration; FIFO_DEPTH must be a power of two */
package cfg_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [15:0] len_t;  // length in words

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    mem_pkg::addr_t src_base;
    mem_pkg::addr_t dst_base;
    len_t           len;
  } cfg_t;

  localparam apb_addr_t REG_SRC    = 8'h00;
  localparam apb_addr_t REG_DST    = 8'h04;
  localparam apb_addr_t REG_LEN    = 8'h08;
  localparam apb_addr_t REG_CTRL   = 8'h0C;  // bit 0 start
  localparam apb_addr_t REG_STATUS = 8'h10;  // bit 0 busy, bit 1 done

  localparam int unsigned FIFO_DEPTH = 4;

  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;
  typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;

endpackage

// ==== rtl/apb_regs.sv ====
/* zero wait state APB target; a start written while busy is dropped,
   done stays set until the next start */
`timescale 1ns/10ps

module apb_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  cfg_pkg::apb_req_t apb_req,
  output cfg_pkg::apb_rsp_t apb_rsp,
  output cfg_pkg::cfg_t     cfg,
  output logic              start,
  input  logic              copy_done,
  output logic              done
);
  import cfg_pkg::*;

  logic access;
  logic wr;
  logic valid_off;
  logic busy_q;
  logic done_q;
  logic start_q;
  cfg_t cfg_q;

  assign access = apb_req.psel & apb_req.penable;  // second phase
  assign wr     = access & apb_req.pwrite;

  always_comb begin
    valid_off = 1'b0;
    apb_rsp   = '0;
    case (apb_req.paddr)
      REG_SRC: begin
        valid_off      = 1'b1;
        apb_rsp.prdata = cfg_q.src_base;
      end
      REG_DST: begin
        valid_off      = 1'b1;
        apb_rsp.prdata = cfg_q.dst_base;
      end
      REG_LEN: begin
        valid_off      = 1'b1;
        apb_rsp.prdata = apb_data_t'(cfg_q.len);
      end
      REG_CTRL: valid_off = 1'b1;  // reads as zero
      REG_STATUS: begin
        valid_off      = 1'b1;
        apb_rsp.prdata = {30'b0, done_q, busy_q};
      end
      default: valid_off = 1'b0;
    endcase
    apb_rsp.pready  = 1'b1;
    // status is read only
    apb_rsp.pslverr = access & (~valid_off | (apb_req.pwrite & (apb_req.paddr == REG_STATUS)));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (wr && apb_req.paddr == REG_SRC) cfg_q.src_base <= apb_req.pwdata;
      if (wr && apb_req.paddr == REG_DST) cfg_q.dst_base <= apb_req.pwdata;
      if (wr && apb_req.paddr == REG_LEN) cfg_q.len <= apb_req.pwdata[15:0];
      start_q <= wr && apb_req.paddr == REG_CTRL && apb_req.pwdata[0] && !busy_q;
      if (start_q) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (copy_done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;  // sticky
      end
    end
  end

  assign cfg   = cfg_q;
  assign start = start_q;
  assign done  = done_q;

endmodule

// ==== streamer/load_engine.sv ====
/* reads len words from src_base upward; only issues a read when the FIFO has room
   for it counting the reads still in flight */
`timescale 1ns/10ps

module load_engine (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start,
  input  cfg_pkg::cfg_t      cfg,
  output mem_pkg::mem_req_t  req,
  input  mem_pkg::mem_rsp_t  rsp,
  output logic               push,
  output mem_pkg::data_t     push_data,
  input  cfg_pkg::fifo_cnt_t fifo_count
);
  import mem_pkg::*;
  import cfg_pkg::*;

  typedef enum logic {IDLE, RUN} state_e;

  state_e                     state_q;
  addr_t                      addr_q;
  len_t                       left_q;      // reads not yet granted
  fifo_cnt_t                  inflight_q;  // granted, no r_valid yet
  logic [$bits(fifo_cnt_t):0] occupancy;
  logic                       granted;

  assign occupancy = fifo_count + inflight_q;

  always_comb begin
    req     = '0;
    req.req = (state_q == RUN) && (occupancy < FIFO_DEPTH);
    req.wen = 1'b1;  // read
    req.add = addr_q;
    req.be  = '1;
  end

  assign granted   = req.req & rsp.gnt;
  assign push      = rsp.r_valid;  // every response is ours
  assign push_data = rsp.r_data;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      left_q     <= '0;
      inflight_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (start && cfg.len != '0) begin
          state_q <= RUN;
          left_q  <= cfg.len;
        end
        RUN: if (granted) begin
          left_q <= left_q - 1'b1;
          if (left_q == len_t'(1)) state_q <= IDLE;  // last read issued
        end
        default: state_q <= IDLE;
      endcase
      case ({granted, rsp.r_valid})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) addr_q <= cfg.src_base;
    else if (granted) addr_q <= addr_q + addr_t'(4);
  end

endmodule

// ==== streamer/store_engine.sv ====
/* writes the FIFO head to dst_base upward; copy_done pulses one cycle after the
   last granted write, or one cycle after start for a zero length */
`timescale 1ns/10ps

module store_engine (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start,
  input  cfg_pkg::cfg_t     cfg,
  output mem_pkg::mem_req_t req,
  input  mem_pkg::mem_rsp_t rsp,
  output logic              pop,
  input  logic              empty,
  input  mem_pkg::data_t    pop_data,
  output logic              copy_done
);
  import mem_pkg::*;
  import cfg_pkg::*;

  typedef enum logic {IDLE, RUN} state_e;

  state_e state_q;
  addr_t  addr_q;
  len_t   left_q;  // writes still to go
  logic   done_q;
  logic   granted;

  // head stays put until popped, so the request fields hold under back-pressure
  always_comb begin
    req      = '0;
    req.req  = (state_q == RUN) && !empty;
    req.wen  = 1'b0;  // write
    req.add  = addr_q;
    req.be   = '1;
    req.data = pop_data;
  end

  assign granted = req.req & rsp.gnt;
  assign pop     = granted;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      left_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= (granted && left_q == len_t'(1)) || (start && cfg.len == '0);
      case (state_q)
        IDLE: if (start && cfg.len != '0) begin
          state_q <= RUN;
          left_q  <= cfg.len;
        end
        RUN: if (granted) begin
          left_q <= left_q - 1'b1;
          if (left_q == len_t'(1)) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) addr_q <= cfg.dst_base;
    else if (granted) addr_q <= addr_q + addr_t'(4);
  end

  assign copy_done = done_q;

endmodule

// ==== streamer/copy_fifo.sv ====
/* fall-through register FIFO; no full flag, the writer must keep its own credit */
`timescale 1ns/10ps

module copy_fifo (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push,
  input  mem_pkg::data_t     push_data,
  input  logic               pop,
  output mem_pkg::data_t     pop_data,
  output logic               empty,
  output cfg_pkg::fifo_cnt_t count
);
  import mem_pkg::*;
  import cfg_pkg::*;

  data_t     mem_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at the power of two
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data;
  end

  assign pop_data = mem_q[rd_ptr_q];  // head word
  assign empty    = (count_q == '0);
  assign count    = count_q;

endmodule

// ==== streamer/ls_mixer.sv ====
/* two-way round-robin mixer onto one memory port; a valid read response is
   always taken as belonging to the load side */
`timescale 1ns/10ps

module ls_mixer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  mem_pkg::mem_req_t load_req,
  input  mem_pkg::mem_req_t store_req,
  output mem_pkg::mem_rsp_t load_rsp,
  output mem_pkg::mem_rsp_t store_rsp,
  output mem_pkg::mem_req_t mem_req,
  input  mem_pkg::mem_rsp_t mem_rsp
);

  logic rr_q;       // 1 favours the store side
  logic sel_store;  // current winner

  always_comb begin
    if (load_req.req && store_req.req) sel_store = rr_q;
    else sel_store = store_req.req;
  end

  assign mem_req = sel_store ? store_req : load_req;

  always_comb begin
    load_rsp      = '0;
    store_rsp     = '0;
    load_rsp.gnt  = mem_rsp.gnt & ~sel_store;  // only the winner sees gnt
    store_rsp.gnt = mem_rsp.gnt & sel_store;
    // writes get no response, so anything valid is a load
    if (mem_rsp.r_valid) begin
      load_rsp.r_valid = 1'b1;
      load_rsp.r_data  = mem_rsp.r_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else if (mem_req.req && mem_rsp.gnt) begin
      rr_q <= ~rr_q;  // flip after every granted cycle
    end
  end

endmodule

// ==== rtl/copy_dma_top.sv ====
/* copy engine top; the memory behind mem_req/mem_rsp is external */
`timescale 1ns/10ps

module copy_dma_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  cfg_pkg::apb_req_t apb_req,
  output cfg_pkg::apb_rsp_t apb_rsp,
  output mem_pkg::mem_req_t mem_req,
  input  mem_pkg::mem_rsp_t mem_rsp,
  output logic              done
);
  import mem_pkg::*;
  import cfg_pkg::*;

  cfg_t      cfg;
  logic      start;
  logic      copy_done;
  mem_req_t  load_req;
  mem_req_t  store_req;
  mem_rsp_t  load_rsp;
  mem_rsp_t  store_rsp;
  logic      push;
  data_t     push_data;
  logic      pop;
  data_t     pop_data;
  logic      empty;
  fifo_cnt_t fifo_count;

  apb_regs u_regs (
    .clk_i, .rst_ni, .apb_req, .apb_rsp, .cfg, .start, .copy_done, .done
  );

  load_engine u_load (
    .clk_i, .rst_ni, .start, .cfg,
    .req  (load_req),
    .rsp  (load_rsp),
    .push, .push_data, .fifo_count
  );

  copy_fifo u_fifo (
    .clk_i, .rst_ni, .push, .push_data, .pop, .pop_data, .empty,
    .count (fifo_count)
  );

  store_engine u_store (
    .clk_i, .rst_ni, .start, .cfg,
    .req  (store_req),
    .rsp  (store_rsp),
    .pop, .empty, .pop_data, .copy_done
  );

  ls_mixer u_mixer (
    .clk_i, .rst_ni, .load_req, .store_req, .load_rsp, .store_rsp, .mem_req, .mem_rsp
  );

endmodule

// ==== tb/dma_props.sv ====
/* bound into copy_dma_top; each write is checked against the source image held in
   tb_top, so source ranges must stay below 0x400 */
`timescale 1ns/10ps

module dma_props (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              start,
  input cfg_pkg::cfg_t     cfg,
  input mem_pkg::mem_req_t load_req,
  input mem_pkg::mem_req_t store_req,
  input mem_pkg::mem_rsp_t load_rsp,
  input mem_pkg::mem_rsp_t store_rsp,
  input mem_pkg::mem_rsp_t mem_rsp
);
  import mem_pkg::*;

  int unsigned fail_cnt = 0;
  addr_t       src_add_q;    // source address of the next write
  addr_t       wr_add_q;     // next destination address
  logic        both_gnt_q;
  logic        store_won_q;
  logic        both;
  logic        wr_hs;

  assign both  = load_req.req & store_req.req;
  assign wr_hs = store_req.req & store_rsp.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_add_q   <= '0;
      wr_add_q    <= '0;
      both_gnt_q  <= 1'b0;
      store_won_q <= 1'b0;
    end else begin
      both_gnt_q  <= both & mem_rsp.gnt;
      store_won_q <= store_rsp.gnt;
      if (start) begin
        src_add_q <= cfg.src_base;
        wr_add_q  <= cfg.dst_base;
      end else if (wr_hs) begin
        src_add_q <= src_add_q + 32'd4;
        wr_add_q  <= wr_add_q + 32'd4;
      end
    end
  end

  a_load_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_req.req && !load_rsp.gnt |=> load_req.req && $stable(load_req))
    else begin $error("load request changed before its grant"); fail_cnt++; end

  a_store_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_req.req && !store_rsp.gnt |=> store_req.req && $stable(store_req))
    else begin $error("store request changed before its grant"); fail_cnt++; end

  // pointer flips once per granted cycle
  a_rr_alternate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    both && mem_rsp.gnt && both_gnt_q |-> store_rsp.gnt != store_won_q)
    else begin $error("mixer picked the same side twice in a row"); fail_cnt++; end

  a_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_rsp.r_valid == $past(load_req.req & load_rsp.gnt, MEM_RD_LATENCY))
    else begin $error("read response not one latency after its grant"); fail_cnt++; end

  a_wr_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_hs |-> store_req.data == tb_top.src_img[src_add_q[9:2]]
              && store_req.add == wr_add_q)
    else begin $error("write does not match the source word or address"); fail_cnt++; end

endmodule

// ==== tb/tb_clk_gen.sv ====
/* 40 ns clock; reset low for the first 16 cycles, released on a falling edge */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule

// ==== tb/tb_top.sv ====
/* copy engine testbench; memory covers 4 KB, source data lives below 0x400 and the
   destinations above it */
`timescale 1ns/10ps

module tb_top;
  import mem_pkg::*;
  import cfg_pkg::*;

  function automatic int unsigned copy_cycles(input int unsigned len);
    return 100 + 16 * len;  // generous bound at a 70 percent grant rate
  endfunction

  localparam int unsigned SEED         = 32'h1c64_a9af;
  localparam int unsigned WORST_CYCLES = 16 + 40 + copy_cycles(12) + copy_cycles(40)
                                         + 20 + copy_cycles(8) + copy_cycles(0);

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic        done;
  data_t       mem [1024];
  data_t       src_img [256];
  mem_req_t    hs_q;  // handshake taken at the last rising edge
  mem_rsp_t    rsp_pipe [MEM_RD_LATENCY];
  int unsigned wr_cnt;
  int unsigned req_cnt;
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_ok;
  string       cur_test;

  tb_clk_gen u_clk (.clk_i, .rst_ni);

  copy_dma_top dut0 (.clk_i, .rst_ni, .apb_req, .apb_rsp, .mem_req, .mem_rsp, .done);

  bind copy_dma_top dma_props u_props (
    .clk_i, .rst_ni, .start, .cfg, .load_req, .store_req, .load_rsp, .store_rsp, .mem_rsp
  );

  // memory model; a handshake seen at one falling edge is served at the next
  always @(negedge clk_i) begin : mem_model
    mem_rsp_t rsp_new;
    rsp_new = '0;
    if (hs_q.req) check_val("byte enable", 32'hf, data_t'(hs_q.be));
    if (hs_q.req && hs_q.wen) begin
      rsp_new.r_valid = 1'b1;
      rsp_new.r_data  = mem[hs_q.add[11:2]];
    end else if (hs_q.req) begin
      mem[hs_q.add[11:2]] = hs_q.data;
      wr_cnt++;
    end
    for (int i = MEM_RD_LATENCY - 1; i > 0; i--) rsp_pipe[i] = rsp_pipe[i - 1];
    rsp_pipe[0] = rsp_new;
    mem_rsp     = rsp_pipe[MEM_RD_LATENCY - 1];
    mem_rsp.gnt = mem_req.req && ($urandom % 100 < 70);
    if (mem_req.req) req_cnt++;
    hs_q     = mem_req;
    hs_q.req = mem_req.req && mem_rsp.gnt;
  end

  function automatic int unsigned fail_total();
    return errors + dut0.u_props.fail_cnt;
  endfunction

  task automatic check_val(input string what, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic slverr);
    @(negedge clk_i);
    apb_req        = '0;
    apb_req.psel   = 1'b1;
    apb_req.pwrite = write;
    apb_req.paddr  = addr;
    apb_req.pwdata = wdata;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #1;  // mid access cycle
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_val("pready", 32'h1, data_t'(apb_rsp.pready));
    @(negedge clk_i);
    apb_req = '0;
  endtask

  task automatic start_copy(input addr_t src, input addr_t dst, input len_t len);
    data_t rd;
    logic  err;
    apb_access(1'b1, REG_SRC, src, rd, err);
    apb_access(1'b1, REG_DST, dst, rd, err);
    apb_access(1'b1, REG_LEN, data_t'(len), rd, err);
    apb_access(1'b1, REG_CTRL, 32'h1, rd, err);
  endtask

  task automatic wait_done(input int unsigned len);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);  // old done is gone one cycle after the start pulse
    while (!done && cycles < copy_cycles(len)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done) begin
      $display("%s: copy did not raise done in time", cur_test);
      errors++;
    end
  endtask

  task automatic check_dest(input addr_t src, input addr_t dst, input int unsigned len);
    for (int unsigned i = 0; i < len; i++) begin
      check_val($sformatf("word %0d", i), src_img[src / 4 + i], mem[dst / 4 + i]);
    end
  endtask

  task automatic end_test(input int unsigned mark);
    tests_run++;
    if (fail_total() == mark) begin
      tests_ok++;
      $display("test %s passed", cur_test);
    end else begin
      $display("test %s FAILED", cur_test);
    end
  endtask

  initial begin
    #(WORST_CYCLES * 4 * 40);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    data_t       rd;
    logic        err;
    int unsigned mark;
    data_t       wval [3];
    apb_addr_t   cfg_regs [3];
    void'($urandom(SEED));
    apb_req   = '0;
    mem_rsp   = '0;
    errors    = 0;
    tests_run = 0;
    tests_ok  = 0;
    wr_cnt    = 0;
    req_cnt   = 0;
    for (int i = 0; i < 1024; i++) mem[i] = data_t'(i) * 32'h9e37_79b9;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = $urandom;
      src_img[i] = mem[i];
    end
    cfg_regs[0] = REG_SRC;
    cfg_regs[1] = REG_DST;
    cfg_regs[2] = REG_LEN;
    wait (rst_ni === 1'b1);

    cur_test = "reg_readback";
    mark     = fail_total();
    for (int r = 0; r < 3; r++) begin
      wval[r] = (r == 2) ? ($urandom & 32'hffff) : $urandom;
      apb_access(1'b1, cfg_regs[r], wval[r], rd, err);
    end
    for (int r = 0; r < 3; r++) begin
      apb_access(1'b0, cfg_regs[r], '0, rd, err);
      check_val($sformatf("reg 0x%02h", cfg_regs[r]), wval[r], rd);
    end
    end_test(mark);

    cur_test = "copy_12";
    mark     = fail_total();
    start_copy(32'h100, 32'h400, 16'd12);
    wait_done(12);
    check_dest(32'h100, 32'h400, 12);
    end_test(mark);

    // long copy keeps both engines busy so the mixer sees contention
    cur_test = "arbitration";
    mark     = fail_total();
    start_copy(32'h200, 32'h800, 16'd40);
    wait_done(40);
    check_dest(32'h200, 32'h800, 40);
    end_test(mark);

    cur_test = "bad_offset";
    mark     = fail_total();
    apb_access(1'b0, 8'h20, '0, rd, err);
    check_val("pslverr on 0x20", 32'h1, data_t'(err));
    apb_access(1'b1, REG_STATUS, 32'h3, rd, err);
    check_val("pslverr on status write", 32'h1, data_t'(err));
    apb_access(1'b0, REG_CTRL, '0, rd, err);
    check_val("pslverr on ctrl read", 32'h0, data_t'(err));
    end_test(mark);

    cur_test = "start_while_busy";
    mark     = fail_total();
    wr_cnt   = 0;
    start_copy(32'h040, 32'hc00, 16'd8);
    apb_access(1'b0, REG_STATUS, '0, rd, err);
    check_val("busy bit", 32'h1, rd & 32'h1);
    apb_access(1'b1, REG_CTRL, 32'h1, rd, err);  // must be dropped
    wait_done(8);
    check_val("write count", 32'd8, wr_cnt);
    apb_access(1'b0, REG_STATUS, '0, rd, err);
    check_val("status after done", 32'h2, rd);
    check_dest(32'h040, 32'hc00, 8);
    end_test(mark);

    cur_test = "zero_length";
    mark     = fail_total();
    req_cnt  = 0;
    start_copy(32'h000, 32'hf00, 16'd0);
    wait_done(0);
    check_val("memory requests", 32'd0, req_cnt);
    apb_access(1'b0, REG_STATUS, '0, rd, err);
    check_val("status after done", 32'h2, rd);
    end_test(mark);

    $display("tests run %0d, passed %0d, failed %0d, check failures %0d",
             tests_run, tests_ok, tests_run - tests_ok, fail_total());
    if (fail_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/mem_pkg.sv
common/cfg_pkg.sv
rtl/apb_regs.sv
streamer/load_engine.sv
streamer/store_engine.sv
streamer/copy_fifo.sv
streamer/ls_mixer.sv
rtl/copy_dma_top.sv
tb/dma_props.sv
tb/tb_clk_gen.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o sim && \
./obj_dir/sim +verilator+error+limit+1000 | tee /dev/stderr | grep -qF "All tests passed!" && \
echo "simulation run: PASS" || { echo "simulation run: FAIL"; exit 1; }
